/* source/core_pkg.sv */
// core package: shared opcodes, ALU operations and pipeline records of the RV32I slice
package core_pkg;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		BRANCH = 7'b1100011
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_e;

	// funct3 encodings shared by OP and OP_IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct3 encodings of the branches
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

	localparam logic [31:0] NOP_INSTR   = 32'h00000033; // add x0, x0, x0
	localparam int unsigned EXC_ILLEGAL = 2;

	// one instruction in flight between decode and execute
	typedef struct packed {
		logic [31:0] read_data_a;
		logic [31:0] read_data_b;
		logic [4:0]  write_addr;
		logic        int_write_enable;
		logic [31:0] exc_bits;
		logic [31:0] instruction;
		logic [31:0] pc;
		logic [31:0] pred_pc;
		logic        prediction;
		logic        taken;
	} dec_exe_t;

	// what the fetch side hands to decode
	typedef struct packed {
		logic [31:0] instruction;
		logic [31:0] pc;
		logic [31:0] pred_pc;
		logic        prediction;
		logic        taken;
	} fetch_t;

	typedef struct packed {
		logic        write_enable;
		logic [4:0]  write_addr;
		logic [31:0] write_data;
	} wb_t;

endpackage

/* source/reg_file.sv */
// register file: 32 x 32 bits, two combinational reads, one synchronous write, x0 reads zero
`timescale 1ns/10ps

module reg_file (
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  logic [4:0]       rs1_addr_i,
	input  logic [4:0]       rs2_addr_i,
	output logic [31:0]      rs1_data_o,
	output logic [31:0]      rs2_data_o,
	input  core_pkg::wb_t    wb_i
);

	logic [31:0] regs [32];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.write_enable && (wb_i.write_addr != 5'd0)) begin
			regs[wb_i.write_addr] <= wb_i.write_data; // x0 is never written so it stays zero
		end
	end

	// reads see the value committed at the previous edge
	always_comb begin
		rs1_data_o = regs[rs1_addr_i];
		rs2_data_o = regs[rs2_addr_i];
	end

endmodule

/* source/decode_stage.sv */
// decode stage: operand read, opcode check, hazard detection against execute and record build
`timescale 1ns/10ps

module decode_stage (
	input  core_pkg::fetch_t   fetch_i,
	input  logic               stall_core_i,
	input  logic [4:0]         exe_write_addr_i,
	input  logic               exe_write_enable_i,
	input  logic [31:0]        rs1_data_i,
	input  logic [31:0]        rs2_data_i,
	output logic [4:0]         rs1_addr_o,
	output logic [4:0]         rs2_addr_o,
	output core_pkg::dec_exe_t dec_o,
	output logic               decode_stall_o,
	output logic               hold_o
);

	core_pkg::opcode_e opcode;
	logic [31:0]       imm_i;
	logic [4:0]        rd;
	logic              uses_rs1;
	logic              uses_rs2;
	logic              writes_rd;
	logic              illegal;
	logic              rs1_hit;
	logic              rs2_hit;

	assign opcode     = core_pkg::opcode_e'(fetch_i.instruction[6:0]);
	assign rs1_addr_o = fetch_i.instruction[19:15];
	assign rs2_addr_o = fetch_i.instruction[24:20];
	assign rd         = fetch_i.instruction[11:7];
	assign imm_i      = {{20{fetch_i.instruction[31]}}, fetch_i.instruction[31:20]};

	always_comb begin
		uses_rs1  = 1'b0;
		uses_rs2  = 1'b0;
		writes_rd = 1'b0;
		illegal   = 1'b0;
		case (opcode)
			core_pkg::OP: begin
				uses_rs1  = 1'b1;
				uses_rs2  = 1'b1;
				writes_rd = 1'b1;
			end
			core_pkg::OP_IMM: begin
				uses_rs1  = 1'b1;
				writes_rd = 1'b1;
			end
			core_pkg::BRANCH: begin
				uses_rs1 = 1'b1; // branches compare both sources
				uses_rs2 = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
	end

	// a source that the instruction in execute is about to overwrite must wait one cycle
	assign rs1_hit = uses_rs1 && (rs1_addr_o != 5'd0) && (rs1_addr_o == exe_write_addr_i);
	assign rs2_hit = uses_rs2 && (rs2_addr_o != 5'd0) && (rs2_addr_o == exe_write_addr_i);

	assign decode_stall_o = exe_write_enable_i && (rs1_hit || rs2_hit);
	assign hold_o         = decode_stall_o || stall_core_i;

	always_comb begin
		dec_o                  = '0;
		dec_o.read_data_a      = rs1_data_i;
		dec_o.read_data_b      = (opcode == core_pkg::OP_IMM) ? imm_i : rs2_data_i;
		dec_o.write_addr       = rd;
		dec_o.int_write_enable = writes_rd;
		dec_o.instruction      = fetch_i.instruction;
		dec_o.pc               = fetch_i.pc;
		dec_o.pred_pc          = fetch_i.pred_pc;
		dec_o.prediction       = fetch_i.prediction;
		dec_o.taken            = fetch_i.taken;
		dec_o.exc_bits[core_pkg::EXC_ILLEGAL] = illegal; // write already off for unknown opcodes
	end

endmodule

/* source/dec_exe_latch.sv */
// decode/execute pipeline register with kill, bubble insertion and core-stall hold
`timescale 1ns/10ps

module dec_exe_latch (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               kill_i,
	input  logic               stall_core_i,
	input  logic               decode_stall_i,
	input  core_pkg::dec_exe_t dec_i,
	output core_pkg::dec_exe_t exe_o
);

	core_pkg::dec_exe_t exe_q;
	core_pkg::dec_exe_t stall_rec;

	// what execute sees while the core is stalled
	always_comb begin
		stall_rec             = '0;
		stall_rec.instruction = core_pkg::NOP_INSTR;
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i || kill_i || (decode_stall_i && !stall_core_i)) begin
			exe_q <= '0; // an all-zero record is a bubble
		end else if (!stall_core_i) begin
			exe_q <= dec_i;
		end
	end

	// the held record comes back once the stall lifts
	assign exe_o = stall_core_i ? stall_rec : exe_q;

endmodule

/* source/exe_stage.sv */
// execute stage: ALU, branch resolution against the prediction, writeback and exception report
`timescale 1ns/10ps

module exe_stage (
	input  core_pkg::dec_exe_t exe_i,
	output core_pkg::wb_t      wb_o,
	output logic               mispredict_o,
	output logic [31:0]        redirect_pc_o,
	output logic               exception_o,
	output logic [31:0]        exc_pc_o
);

	core_pkg::opcode_e opcode;
	core_pkg::alu_op_e alu_op;
	logic [2:0]        funct3;
	logic [31:0]       a;
	logic [31:0]       b;
	logic [31:0]       result;
	logic [31:0]       imm_b;
	logic [31:0]       target;
	logic              is_branch;
	logic              actual_taken;
	logic              pred_taken;

	assign opcode = core_pkg::opcode_e'(exe_i.instruction[6:0]);
	assign funct3 = exe_i.instruction[14:12];
	assign a      = exe_i.read_data_a;
	assign b      = exe_i.read_data_b;

	always_comb begin
		case (funct3)
			core_pkg::F3_SLT: alu_op = core_pkg::ALU_SLT;
			core_pkg::F3_XOR: alu_op = core_pkg::ALU_XOR;
			core_pkg::F3_OR:  alu_op = core_pkg::ALU_OR;
			core_pkg::F3_AND: alu_op = core_pkg::ALU_AND;
			default: begin
				// funct7 bit 30 selects SUB only for register-register ops
				if ((opcode == core_pkg::OP) && exe_i.instruction[30]) begin
					alu_op = core_pkg::ALU_SUB;
				end else begin
					alu_op = core_pkg::ALU_ADD;
				end
			end
		endcase
	end

	always_comb begin
		case (alu_op)
			core_pkg::ALU_SUB: result = a - b;
			core_pkg::ALU_AND: result = a & b;
			core_pkg::ALU_OR:  result = a | b;
			core_pkg::ALU_XOR: result = a ^ b;
			core_pkg::ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
			default:           result = a + b;
		endcase
	end

	assign imm_b = {{20{exe_i.instruction[31]}}, exe_i.instruction[7],
		exe_i.instruction[30:25], exe_i.instruction[11:8], 1'b0};
	assign target = exe_i.pc + imm_b;

	assign is_branch = (opcode == core_pkg::BRANCH) &&
		((funct3 == core_pkg::F3_BEQ) || (funct3 == core_pkg::F3_BNE));
	assign actual_taken = (funct3 == core_pkg::F3_BEQ) ? (a == b) : (a != b);
	assign pred_taken   = exe_i.prediction && exe_i.taken;

	// a taken branch is also wrong when fetch went to another address
	assign mispredict_o = is_branch && ((actual_taken != pred_taken) ||
		(actual_taken && (exe_i.pred_pc != target)));
	assign redirect_pc_o = actual_taken ? target : exe_i.pc + 32'd4;

	assign exception_o = |exe_i.exc_bits;
	assign exc_pc_o    = exe_i.pc;

	assign wb_o.write_enable = exe_i.int_write_enable && (exe_i.exc_bits == 32'd0);
	assign wb_o.write_addr   = exe_i.write_addr;
	assign wb_o.write_data   = result;

endmodule

/* source/dec_exe_top.sv */
// top level of the pipeline slice: register file, decode, decode/execute register and execute
`timescale 1ns/10ps

module dec_exe_top (
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  core_pkg::fetch_t fetch_i,
	input  logic             stall_core_i,
	output logic             hold_o,
	output core_pkg::wb_t    wb_o,
	output logic             mispredict_o,
	output logic [31:0]      redirect_pc_o,
	output logic             exception_o,
	output logic [31:0]      exc_pc_o
);

	logic [4:0]         rs1_addr;
	logic [4:0]         rs2_addr;
	logic [31:0]        rs1_data;
	logic [31:0]        rs2_data;
	logic               decode_stall;
	core_pkg::dec_exe_t dec_rec;
	core_pkg::dec_exe_t exe_rec;

	reg_file reg_file_i (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wb_i       (wb_o)
	);

	// the hazard check looks at the write execute is about to commit
	decode_stage decode_stage_i (
		.fetch_i            (fetch_i),
		.stall_core_i       (stall_core_i),
		.exe_write_addr_i   (wb_o.write_addr),
		.exe_write_enable_i (wb_o.write_enable),
		.rs1_data_i         (rs1_data),
		.rs2_data_i         (rs2_data),
		.rs1_addr_o         (rs1_addr),
		.rs2_addr_o         (rs2_addr),
		.dec_o              (dec_rec),
		.decode_stall_o     (decode_stall),
		.hold_o             (hold_o)
	);

	dec_exe_latch dec_exe_latch_i (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.kill_i         (mispredict_o),
		.stall_core_i   (stall_core_i),
		.decode_stall_i (decode_stall),
		.dec_i          (dec_rec),
		.exe_o          (exe_rec)
	);

	exe_stage exe_stage_i (
		.exe_i         (exe_rec),
		.wb_o          (wb_o),
		.mispredict_o  (mispredict_o),
		.redirect_pc_o (redirect_pc_o),
		.exception_o   (exception_o),
		.exc_pc_o      (exc_pc_o)
	);

endmodule

/* dv/tb_clock.sv */
// testbench clock and reset: 20 ns clock, active-low reset held for 16 cycles
`timescale 1ns/10ps

module tb_clock (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (16) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1; // released away from the active edge
	end

endmodule

/* dv/dec_exe_tb.sv */
// testbench of the decode/execute slice: table of instructions, reference model and checks
`timescale 1ns/10ps

module dec_exe_tb;

	typedef struct packed {
		core_pkg::fetch_t fetch;
		logic [3:0]       stall_cycles;
		logic             wrong_path;
		logic [3:0]       test_id;
	} entry_t;

	// what execute should show for the instruction it holds
	typedef struct packed {
		logic        we;
		logic [4:0]  addr;
		logic [31:0] data;
		logic        mis;
		logic [31:0] redirect;
		logic        exc;
		logic [31:0] exc_pc;
	} exp_t;

	logic             clk;
	logic             rst_n;
	core_pkg::fetch_t fetch_i;
	logic             stall_core_i;
	logic             hold_o;
	core_pkg::wb_t    wb_o;
	logic             mispredict_o;
	logic [31:0]      redirect_pc_o;
	logic             exception_o;
	logic [31:0]      exc_pc_o;

	entry_t      tbl [64];
	string       test_names [5];
	int          n_entries;
	int          errors;
	int          checks;
	logic [31:0] pc_next;
	logic [31:0] mregs [32];
	logic        table_ready;

	tb_clock clock_i (.clk_o(clk), .rst_n_o(rst_n));

	dec_exe_top dut_i (
		.clk_i         (clk),
		.rst_n_i       (rst_n),
		.fetch_i       (fetch_i),
		.stall_core_i  (stall_core_i),
		.hold_o        (hold_o),
		.wb_o          (wb_o),
		.mispredict_o  (mispredict_o),
		.redirect_pc_o (redirect_pc_o),
		.exception_o   (exception_o),
		.exc_pc_o      (exc_pc_o)
	);

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] alu_model(core_pkg::alu_op_e op, logic [31:0] a,
		logic [31:0] b);
		case (op)
			core_pkg::ALU_ADD: return a + b;
			core_pkg::ALU_SUB: return a - b;
			core_pkg::ALU_AND: return a & b;
			core_pkg::ALU_OR:  return a | b;
			core_pkg::ALU_XOR: return a ^ b;
			default:           return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		endcase
	endfunction

	// expected execute outputs of one instruction, with operands from the model registers
	function automatic exp_t model_exec(core_pkg::fetch_t f);
		exp_t              e;
		logic [6:0]        opc;
		logic [2:0]        f3;
		logic [31:0]       a;
		logic [31:0]       b;
		logic [31:0]       target;
		logic              act;
		core_pkg::alu_op_e op;
		e   = '0;
		opc = f.instruction[6:0];
		f3  = f.instruction[14:12];
		a   = mregs[f.instruction[19:15]];
		b   = mregs[f.instruction[24:20]];
		if (opc == core_pkg::OP_IMM) b = {{20{f.instruction[31]}}, f.instruction[31:20]};
		if (opc == core_pkg::OP || opc == core_pkg::OP_IMM) begin
			case (f3)
				3'b010:  op = core_pkg::ALU_SLT;
				3'b100:  op = core_pkg::ALU_XOR;
				3'b110:  op = core_pkg::ALU_OR;
				3'b111:  op = core_pkg::ALU_AND;
				default: op = (opc == core_pkg::OP && f.instruction[30]) ? core_pkg::ALU_SUB
					: core_pkg::ALU_ADD;
			endcase
			e.we   = 1'b1;
			e.addr = f.instruction[11:7];
			e.data = alu_model(op, a, b);
		end else if (opc == core_pkg::BRANCH) begin
			target = f.pc + {{19{f.instruction[31]}}, f.instruction[31], f.instruction[7],
				f.instruction[30:25], f.instruction[11:8], 1'b0};
			act        = (f3 == 3'b000) ? (a == b) : (a != b);
			e.mis      = (act != (f.prediction && f.taken)) || (act && f.pred_pc != target);
			e.redirect = act ? target : f.pc + 32'd4;
		end else begin
			e.exc    = 1'b1;
			e.exc_pc = f.pc;
		end
		return e;
	endfunction

	// true when the entry reads a nonzero register that execute is writing
	function automatic logic needs_wait(core_pkg::fetch_t f, exp_t e);
		logic [6:0] opc;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic       r1;
		logic       r2;
		opc = f.instruction[6:0];
		rs1 = f.instruction[19:15];
		rs2 = f.instruction[24:20];
		r1  = (opc == core_pkg::OP || opc == core_pkg::OP_IMM || opc == core_pkg::BRANCH);
		r2  = (opc == core_pkg::OP || opc == core_pkg::BRANCH);
		return e.we && e.addr != 5'd0 &&
			((r1 && rs1 == e.addr) || (r2 && rs2 == e.addr));
	endfunction

	task automatic add_entry(logic [3:0] tid, logic [31:0] instr, logic [31:0] pred_pc,
		logic pred, logic tkn, logic [3:0] stall, logic wrong);
		tbl[n_entries].fetch        = {instr, pc_next, pred_pc, pred, tkn};
		tbl[n_entries].stall_cycles = stall;
		tbl[n_entries].wrong_path   = wrong;
		tbl[n_entries].test_id      = tid;
		n_entries++;
		pc_next = pc_next + 32'd4;
	endtask

	task automatic add_op(logic [3:0] tid, logic [31:0] instr, logic [3:0] stall);
		add_entry(tid, instr, pc_next + 32'd4, 1'b0, 1'b0, stall, 1'b0);
	endtask

	function automatic logic [11:0] rand_imm();
		logic [31:0] r;
		r = $urandom();
		return r[11:0];
	endfunction

	task automatic compare_signal(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_outputs(exp_t e);
		compare_signal("wb_o.write_enable", wb_o.write_enable, e.we);
		if (e.we) begin
			compare_signal("wb_o.write_addr", wb_o.write_addr, e.addr);
			compare_signal("wb_o.write_data", wb_o.write_data, e.data);
		end
		compare_signal("mispredict_o", mispredict_o, e.mis);
		if (e.mis) compare_signal("redirect_pc_o", redirect_pc_o, e.redirect);
		compare_signal("exception_o", exception_o, e.exc);
		if (e.exc) compare_signal("exc_pc_o", exc_pc_o, e.exc_pc);
	endtask

	task automatic commit(exp_t e);
		if (e.we && e.addr != 5'd0) mregs[e.addr] = e.data;
	endtask

	task automatic build_table();
		logic [31:0] bp;
		test_names[0] = "alu operations";
		test_names[1] = "back-to-back dependency";
		test_names[2] = "core stall";
		test_names[3] = "branch prediction";
		test_names[4] = "illegal opcode";
		add_op(0, enc_i(rand_imm(), 5'd0, 3'b000, 5'd1), 0);
		add_op(0, enc_i(rand_imm(), 5'd0, 3'b100, 5'd2), 0);
		add_op(0, enc_i(rand_imm(), 5'd0, 3'b110, 5'd3), 0);
		add_op(0, enc_i(rand_imm(), 5'd1, 3'b111, 5'd4), 0);
		add_op(0, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), 0);
		add_op(0, enc_r(7'h20, 5'd3, 5'd1, 3'b000, 5'd6), 0);
		add_op(0, enc_r(7'h00, 5'd3, 5'd2, 3'b111, 5'd7), 0);
		add_op(0, enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd8), 0);
		add_op(0, enc_r(7'h00, 5'd1, 5'd3, 3'b100, 5'd9), 0);
		add_op(0, enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd10), 0);
		add_op(0, enc_i(rand_imm(), 5'd2, 3'b000, 5'd11), 0);
		add_op(1, enc_i(rand_imm(), 5'd1, 3'b000, 5'd12), 0);
		add_op(1, enc_r(7'h00, 5'd12, 5'd12, 3'b000, 5'd13), 0);
		add_op(1, enc_r(7'h20, 5'd1, 5'd13, 3'b000, 5'd14), 0);
		add_op(2, enc_i(rand_imm(), 5'd2, 3'b000, 5'd15), 3);
		add_op(2, enc_r(7'h00, 5'd3, 5'd15, 3'b000, 5'd16), 2);
		add_op(3, enc_i(12'd5, 5'd0, 3'b000, 5'd17), 0);
		add_op(3, enc_i(12'd9, 5'd0, 3'b000, 5'd18), 0);
		bp = pc_next; // taken but predicted not taken
		add_entry(3, enc_b(13'd16, 5'd17, 5'd17, 3'b000), bp + 32'd4, 1'b0, 1'b0, 0, 1'b0);
		add_entry(3, enc_i(12'd1, 5'd0, 3'b000, 5'd20), pc_next + 32'd4, 1'b0, 1'b0, 0, 1'b1);
		pc_next = bp + 32'd16;
		add_entry(3, enc_b(13'd8, 5'd17, 5'd17, 3'b001), pc_next + 32'd4, 1'b0, 1'b0, 0, 1'b0);
		bp = pc_next; // taken and predicted with the right target
		add_entry(3, enc_b(13'd12, 5'd18, 5'd17, 3'b001), bp + 32'd12, 1'b1, 1'b1, 0, 1'b0);
		pc_next = bp + 32'd12;
		bp = pc_next;
		add_entry(3, enc_b(13'd20, 5'd18, 5'd17, 3'b000), bp + 32'd20, 1'b1, 1'b1, 0, 1'b0);
		add_entry(3, enc_i(12'd2, 5'd0, 3'b000, 5'd21), pc_next + 32'd4, 1'b0, 1'b0, 0, 1'b1);
		pc_next = bp + 32'd4;
		bp = pc_next; // right direction, wrong target
		add_entry(3, enc_b(13'd8, 5'd18, 5'd17, 3'b001), bp + 32'd32, 1'b1, 1'b1, 0, 1'b0);
		add_entry(3, enc_i(12'd3, 5'd0, 3'b000, 5'd22), pc_next + 32'd4, 1'b0, 1'b0, 0, 1'b1);
		pc_next = bp + 32'd8;
		add_op(3, enc_r(7'h00, 5'd18, 5'd17, 3'b000, 5'd19), 0);
		add_op(4, {25'h1f0a5c3, 7'b1111111}, 0);
		add_op(4, core_pkg::NOP_INSTR, 0);
		add_op(4, core_pkg::NOP_INSTR, 0);
	endtask

	initial begin
		int               limit;
		wait (table_ready);
		limit = (n_entries * 4 + 16) * 20;
		#(limit);
		$display("timeout: the table was not consumed within %0d ns", limit);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		exp_t        exe_exp;
		logic        done;
		logic        killed;
		logic        hazard;
		logic        kill;
		logic        held;
		int          stall_left;
		int          holds;
		int          test_errors;
		fetch_i      = '0;
		stall_core_i = 1'b0;
		n_entries    = 0;
		errors       = 0;
		checks       = 0;
		pc_next      = 32'h00001000;
		table_ready  = 1'b0;
		exe_exp      = '0;
		test_errors  = 0;
		for (int r = 0; r < 32; r++) mregs[r] = '0;
		void'($urandom(32'h7e373e45));
		build_table();
		table_ready = 1'b1;
		@(posedge rst_n); // reset lifts on a falling edge, before the first accepting edge
		for (int i = 0; i < n_entries; i++) begin
			done       = 1'b0;
			killed     = 1'b0;
			holds      = 0;
			stall_left = tbl[i].stall_cycles;
			while (!done) begin
				fetch_i      = tbl[i].fetch;
				stall_core_i = (stall_left > 0);
				#5;
				check_outputs(stall_core_i ? exp_t'('0) : exe_exp);
				hazard = !stall_core_i && needs_wait(fetch_i, exe_exp);
				kill   = !stall_core_i && exe_exp.mis;
				compare_signal("hold_o", hold_o, stall_core_i || hazard);
				held = hold_o;
				if (mispredict_o) killed = 1'b1;
				if (held && !stall_core_i) holds++;
				@(posedge clk);
				if (stall_core_i) begin
					stall_left--; // execute keeps its instruction
				end else begin
					commit(exe_exp);
					if (kill) begin
						exe_exp = '0;
						done    = 1'b1;
					end else if (held) begin
						exe_exp = '0;
					end else begin
						exe_exp = model_exec(tbl[i].fetch);
						done    = 1'b1;
					end
				end
				@(negedge clk);
			end
			assert (killed == tbl[i].wrong_path) else begin
				$display("entry %0d: mispredict kill was %0b but the table marks wrong path %0b",
					i, killed, tbl[i].wrong_path);
				errors++;
			end
			assert (holds <= 1) else begin
				$display("entry %0d: a dependency held decode for %0d cycles", i, holds);
				errors++;
			end
			if (i == n_entries - 1 || tbl[i + 1].test_id != tbl[i].test_id) begin
				$display("test %0d (%s): %0d errors", tbl[i].test_id,
					test_names[tbl[i].test_id], errors - test_errors);
				test_errors = errors;
			end
		end
		#5;
		check_outputs(exe_exp);
		$display("done: %0d entries, %0d checks, %0d errors", n_entries, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* tb.f */
source/core_pkg.sv
source/reg_file.sv
source/decode_stage.sv
source/dec_exe_latch.sv
source/exe_stage.sv
source/dec_exe_top.sv
dv/tb_clock.sv
dv/dec_exe_tb.sv

/* Bender.yml */
package:
  name: dec_exe

sources:
  - files:
      - source/core_pkg.sv
      - source/reg_file.sv
      - source/decode_stage.sv
      - source/dec_exe_latch.sv
      - source/exe_stage.sv
      - source/dec_exe_top.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/dec_exe_tb.sv
